// File: Bender.yml
package:
  name: window_sum

dependencies: {}

sources:
  # rtl in compile order
  - files:
      - verilog/wsum_pkg.sv
      - verilog/pix_rd_if.sv
      - verilog/res_if.sv
      - verilog/frame_loader.sv
      - verilog/row_controller.sv
      - verilog/window_accum.sv
      - verilog/result_queue.sv
      - verilog/window_sum_top.sv

  # testbench
  - target: simulation
    files:
      - testbench/tb_window_sum.sv

// File: list.f
verilog/wsum_pkg.sv
verilog/pix_rd_if.sv
verilog/res_if.sv
verilog/frame_loader.sv
verilog/row_controller.sv
verilog/window_accum.sv
verilog/result_queue.sv
verilog/window_sum_top.sv
testbench/tb_window_sum.sv

// File: testbench/tb_window_sum.sv
`timescale 1ns/1ps

module tb_window_sum import wsum_pkg::*; ();

  localparam int N_RES     = ROWS * (COLS - WIN + 1);
  localparam int N_FRAMES  = 5;
  localparam int APB_CYC   = 2 * (ROWS * COLS + 8);
  localparam int LIMIT     = N_FRAMES * (ROWS * COLS * 8 + APB_CYC) + 16;
  localparam int DRAIN_CYC = 16 * (Q_DEPTH + 2);

  logic             clk;
  logic             rst_n;
  logic             psel;
  logic             penable;
  logic             pwrite;
  logic [7:0]       paddr;
  logic [31:0]      pwdata;
  logic [31:0]      prdata;
  logic             pready;
  logic             res_valid;
  logic [ROW_W-1:0] res_row;
  logic [COL_W-1:0] res_col;
  logic [SUM_W-1:0] res_sum;
  logic             res_ready;
  logic             frame_done;

  logic [PIX_W-1:0] pix [ROWS][COLS];
  logic [PIX_W-1:0] saved [ROWS][COLS];
  logic [RES_W-1:0] exp_q [$];
  logic [RES_W-1:0] exp_word;
  logic [RES_W-1:0] held_word;
  logic             hold_pend;
  logic [31:0]      pix_seed;
  logic [31:0]      rdy_seed;
  logic             ready_random;
  logic [31:0]      rd_data;
  int               got_cnt;
  int               done_cnt;

  window_sum_top u_window_sum_top (
    .clk(clk), .rst_n(rst_n),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .res_valid(res_valid), .res_row(res_row), .res_col(res_col),
    .res_sum(res_sum), .res_ready(res_ready), .frame_done(frame_done)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // sum of WIN pixels starting at column j of row r.
  function automatic logic [SUM_W-1:0] expected_sum(input int r, input int j);
    int acc;
    acc = 0;
    for (int k = 0; k < WIN; k++) begin
      acc += pix[r][j + k];
    end
    return SUM_W'(acc);
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_sum(input logic [SUM_W-1:0] got, input logic [SUM_W-1:0] exp);
    if (got !== exp) report_error($sformatf("FAILED res_sum got %h expected %h", got, exp));
  endtask

  task automatic check_row(input logic [ROW_W-1:0] got, input logic [ROW_W-1:0] exp);
    if (got !== exp) report_error($sformatf("FAILED res_row got %h expected %h", got, exp));
  endtask

  task automatic check_col(input logic [COL_W-1:0] got, input logic [COL_W-1:0] exp);
    if (got !== exp) report_error($sformatf("FAILED res_col got %h expected %h", got, exp));
  endtask

  task automatic check_status(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) report_error($sformatf("FAILED prdata status got %h expected %h", got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) report_error($sformatf("FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) report_error($sformatf("FAILED %s got %h expected %h", name, got, exp));
  endtask

  // both tasks start and end 2 ns after a rising edge.
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(negedge clk);
    data = prdata;  // access phase, before the completing edge.
    check_flag("pready", pready, 1'b1);
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // mode 0 random, 1 all 255, 2 all zero, 3 copy of the first frame.
  task automatic fill_frame(input int mode);
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        case (mode)
          0: begin
            pix_seed = xorshift32(pix_seed);
            pix[r][c] = pix_seed[PIX_W-1:0];
          end
          1:       pix[r][c] = '1;
          2:       pix[r][c] = '0;
          default: pix[r][c] = saved[r][c];
        endcase
      end
    end
  endtask

  // writes the frame, queues the expected words, runs and checks status.
  task automatic process_frame();
    int done_before;
    int drain;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        apb_write(PIX_BASE + 8'(4 * (r * COLS + c)), 32'(pix[r][c]));
      end
    end
    for (int r = 0; r < ROWS; r++) begin
      for (int j = 0; j <= COLS - WIN; j++) begin
        exp_q.push_back({ROW_W'(r), COL_W'(j), expected_sum(r, j)});
      end
    end
    done_before = done_cnt;
    got_cnt = 0;
    apb_write(REG_CTRL, 32'h1);
    while (done_cnt == done_before) @(posedge clk);
    // the last words of a frame drain within a few queue depths.
    drain = 0;
    while (exp_q.size() != 0 && drain < DRAIN_CYC) begin
      @(posedge clk);
      drain++;
    end
    repeat (4) @(posedge clk);
    #2;
    check_count("result count", got_cnt, N_RES);
    check_flag("res_valid", res_valid, 1'b0);
    apb_read(REG_STATUS, rd_data);
    check_status(rd_data, 32'h2);  // done set, busy clear.
    apb_read(REG_STATUS, rd_data);
    check_status(rd_data, 32'h0);
  endtask

  // the sink side drives ready off its own random stream.
  always @(posedge clk) begin
    #2;
    if (ready_random) begin
      rdy_seed = xorshift32(rdy_seed);
      res_ready = rdy_seed[9];
    end else begin
      res_ready = 1'b1;
    end
  end

  // compare process, sampled mid-cycle where outputs are settled.
  always @(negedge clk) begin
    if (rst_n) begin
      if (frame_done) done_cnt++;
      if (hold_pend) begin
        if (!res_valid) begin
          report_error("res_valid went low before the held word was accepted");
        end else begin
          check_row(res_row, held_word[RES_W-1 -: ROW_W]);
          check_col(res_col, held_word[SUM_W +: COL_W]);
          check_sum(res_sum, held_word[SUM_W-1:0]);
        end
      end
      if (res_valid && res_ready) begin
        if (exp_q.size() == 0) begin
          report_error("a result word was accepted while none was expected");
        end else begin
          exp_word = exp_q.pop_front();
          check_row(res_row, exp_word[RES_W-1 -: ROW_W]);
          check_col(res_col, exp_word[SUM_W +: COL_W]);
          check_sum(res_sum, exp_word[SUM_W-1:0]);
          got_cnt++;
        end
      end
      hold_pend = res_valid && !res_ready;
      held_word = {res_row, res_col, res_sum};
    end
  end

  initial begin
    repeat (LIMIT) @(posedge clk);
    report_error("watchdog expired before all frames were finished");
  end

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    res_ready    = 1'b1;
    ready_random = 1'b0;
    hold_pend    = 1'b0;
    pix_seed     = 32'h181f;
    rdy_seed     = 32'h181f;
    got_cnt      = 0;
    done_cnt     = 0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    check_flag("res_valid", res_valid, 1'b0);
    check_flag("frame_done", frame_done, 1'b0);
    apb_read(REG_STATUS, rd_data);
    check_status(rd_data, 32'h0);

    fill_frame(0);
    saved = pix;
    process_frame();
    fill_frame(1);  // full scale, 255 * WIN per window.
    process_frame();
    fill_frame(2);
    process_frame();
    fill_frame(3);
    ready_random = 1'b1;
    process_frame();
    ready_random = 1'b0;
    fill_frame(0);
    process_frame();

    check_count("frame_done pulses", done_cnt, N_FRAMES);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: verilog/frame_loader.sv
`timescale 1ns/1ps

module frame_loader import wsum_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  pix_rd_if.server    rd,
  input  logic        frame_done,
  output logic        go
);

  logic [PIX_W-1:0]  mem [ROWS*COLS];
  logic              wr_acc;
  logic              rd_acc;
  logic              pix_sel;
  logic [ADDR_W-1:0] pix_idx;
  logic              start_wr;
  logic              status_rd;
  logic              done;

  assign pready = 1'b1;  // zero wait states.

  assign wr_acc  = psel && penable && pwrite;
  assign rd_acc  = psel && penable && !pwrite;
  assign pix_sel = (paddr[1:0] == 2'b00);
  assign pix_idx = ADDR_W'((paddr - PIX_BASE) >> 2);

  // a start is only taken while no frame is in flight.
  assign start_wr  = wr_acc && (paddr == REG_CTRL) && pwdata[0] &&
                     !rd.frame_ready && !rd.busy;
  assign status_rd = rd_acc && (paddr == REG_STATUS);

  always_ff @(posedge clk) begin
    if (wr_acc && pix_sel) begin
      mem[pix_idx] <= pwdata[PIX_W-1:0];
    end
  end

  // two read ports for the new and the dropped pixel.
  always_ff @(posedge clk) begin
    if (rd.rd_en) begin
      rd.data_new <= mem[rd.addr_new];
      rd.data_old <= mem[rd.addr_old];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      go             <= 1'b0;
      rd.frame_ready <= 1'b0;
    end else begin
      go <= start_wr;
      if (start_wr) begin
        rd.frame_ready <= 1'b1;
      end else if (frame_done) begin
        rd.frame_ready <= 1'b0;
      end
    end
  end

  // sticky done, set wins over a clearing read.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else if (frame_done) begin
      done <= 1'b1;
    end else if (status_rd) begin
      done <= 1'b0;
    end
  end

  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      if (paddr == REG_CTRL) begin
        prdata[0] = rd.frame_ready;
      end else if (paddr == REG_STATUS) begin
        prdata[1:0] = {done, rd.busy};
      end else if (pix_sel) begin
        prdata[PIX_W-1:0] = mem[pix_idx];
      end
    end
  end

  // setup phase is always followed by an access phase to the same address.
  a_apb_addr_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (psel && !penable) |=> (psel && penable && $stable(paddr))
  );

endmodule

// File: verilog/pix_rd_if.sv
`timescale 1ns/1ps

interface pix_rd_if import wsum_pkg::*; ();
  logic              rd_en;
  logic [ADDR_W-1:0] addr_new;
  logic [ADDR_W-1:0] addr_old;
  logic [PIX_W-1:0]  data_new;   // valid one cycle after rd_en.
  logic [PIX_W-1:0]  data_old;
  logic              frame_ready;
  logic              busy;

  modport server (
    input  rd_en, addr_new, addr_old, busy,
    output data_new, data_old, frame_ready
  );

  modport client (
    output rd_en, addr_new, addr_old, busy,
    input  frame_ready
  );

  modport data (input data_new, data_old);

endinterface

// File: verilog/res_if.sv
`timescale 1ns/1ps

interface res_if import wsum_pkg::*; ();
  logic             valid;
  logic [ROW_W-1:0] row;
  logic [COL_W-1:0] col;    // start column of the window.
  logic [SUM_W-1:0] sum;
  logic             ready;  // queue has room.

  modport producer (
    output valid, row, col, sum,
    input  ready
  );

  modport consumer (
    input  valid, row, col, sum,
    output ready
  );

endinterface

// File: verilog/result_queue.sv
`timescale 1ns/1ps

module result_queue import wsum_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  res_if.consumer          res,
  output logic             res_valid,
  output logic [ROW_W-1:0] res_row,
  output logic [COL_W-1:0] res_col,
  output logic [SUM_W-1:0] res_sum,
  input  logic             res_ready
);

  logic [RES_W-1:0]             mem [Q_DEPTH];
  logic [$clog2(Q_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(Q_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(Q_DEPTH+1)-1:0] count;
  logic                         push;
  logic                         pop;

  assign res.ready = (count != Q_DEPTH);
  assign push      = res.valid && res.ready;
  assign res_valid = (count != '0);
  assign pop       = res_valid && res_ready;

  assign {res_row, res_col, res_sum} = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= {res.row, res.col, res.sum};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == Q_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == Q_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  // pointer distance must match the fill level.
  a_ptr_count: assert property (
    @(posedge clk) disable iff (!rst_n)
    (count <= Q_DEPTH) && (wr_ptr == rd_ptr + count[$clog2(Q_DEPTH)-1:0])
  );

endmodule

// File: verilog/row_controller.sv
`timescale 1ns/1ps

module row_controller import wsum_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             go,
  pix_rd_if.client         rd,
  input  logic             stall,
  output logic             ld_en,
  output logic             sum_en,
  output logic             slide_en,
  output logic [ROW_W-1:0] row,
  output logic [COL_W-1:0] col,
  output logic             frame_done
);

  ctrl_state_t      state;
  ctrl_state_t      next_state;
  logic [COL_W-1:0] col_cnt;
  logic [ROW_W-1:0] row_cnt;
  logic             last_col;
  logic             last_row;

  assign last_col = (col_cnt == COL_W'(COLS - 1));
  assign last_row = (row_cnt == ROW_W'(ROWS - 1));

  always_comb begin
    case (state)
      IDLE:      next_state = go ? START : IDLE;
      START:     next_state = rd.frame_ready ? START_ROW : START;
      START_ROW: next_state = FILL;
      FILL:      next_state = (col_cnt == COL_W'(WIN - 1)) ? SLIDE : FILL;
      SLIDE: begin
        if (last_col) begin
          next_state = last_row ? FINISH : START_ROW;
        end else begin
          next_state = SLIDE;
        end
      end
      FINISH:    next_state = IDLE;
      default:   next_state = IDLE;
    endcase
  end

  // everything holds while the result side is blocked.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= IDLE;
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (!stall) begin
      state <= next_state;
      case (state)
        START:     row_cnt <= '0;
        START_ROW: col_cnt <= '0;
        FILL:      col_cnt <= col_cnt + 1'b1;
        SLIDE: begin
          col_cnt <= col_cnt + 1'b1;
          if (last_col && !last_row) begin
            row_cnt <= row_cnt + 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  assign rd.rd_en    = ((state == FILL) || (state == SLIDE)) && !stall;
  assign rd.addr_new = ADDR_W'(row_cnt * COLS + col_cnt);
  assign rd.addr_old = ADDR_W'(row_cnt * COLS + col_cnt - WIN);  // only read in SLIDE.
  assign rd.busy     = (state != IDLE);

  assign frame_done = (state == FINISH) && !stall;

  // controls line up with the read data one cycle later.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ld_en    <= 1'b0;
      sum_en   <= 1'b0;
      slide_en <= 1'b0;
    end else if (!stall) begin
      ld_en    <= (state == START_ROW);
      sum_en   <= (state == FILL);
      slide_en <= (state == SLIDE);
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      row <= row_cnt;
      col <= col_cnt;
    end
  end

  // the column counter must agree with the phase it drives.
  a_col_phase: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state != FILL || col_cnt < COL_W'(WIN)) &&
    (state != SLIDE || col_cnt >= COL_W'(WIN))
  );

  a_ld_then_fill: assert property (
    @(posedge clk) disable iff (!rst_n)
    (ld_en && !stall) |=> sum_en
  );

endmodule

// File: verilog/window_accum.sv
`timescale 1ns/1ps

module window_accum import wsum_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             ld_en,
  input  logic             sum_en,
  input  logic             slide_en,
  input  logic [ROW_W-1:0] row,
  input  logic [COL_W-1:0] col,
  pix_rd_if.data           rd,
  res_if.producer          res,
  output logic             stall
);

  logic [SUM_W-1:0] sum;
  logic             flush_pend;  // last window of a row still to go out.
  logic [ROW_W-1:0] flush_row;
  logic             emit;

  assign stall = res.valid && !res.ready;
  assign emit  = slide_en || flush_pend;

  always_ff @(posedge clk) begin
    if (!stall) begin
      if (ld_en) begin
        sum <= '0;
      end else if (sum_en) begin
        sum <= sum + SUM_W'(rd.data_new);
      end else if (slide_en) begin
        sum <= sum + SUM_W'(rd.data_new) - SUM_W'(rd.data_old);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flush_pend <= 1'b0;
    end else if (!stall) begin
      flush_pend <= slide_en && (col == COL_W'(COLS - 1));
    end
  end

  always_ff @(posedge clk) begin
    if (!stall && slide_en) begin
      flush_row <= row;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res.valid <= 1'b0;
    end else if (!stall) begin
      res.valid <= emit;  // a taken word is replaced or dropped here.
    end
  end

  // sum still holds the window ending one column back.
  always_ff @(posedge clk) begin
    if (!stall && emit) begin
      res.row <= flush_pend ? flush_row : row;
      res.col <= flush_pend ? COL_W'(COLS - WIN) : col - COL_W'(WIN);
      res.sum <= sum;
    end
  end

  // every result names a real window start and stays within full scale.
  a_res_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    res.valid |-> (res.col <= COL_W'(COLS - WIN)) &&
                  (res.sum <= SUM_W'(WIN * (2**PIX_W - 1)))
  );

endmodule

// File: verilog/window_sum_top.sv
`timescale 1ns/1ps

module window_sum_top import wsum_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  logic [7:0]       paddr,
  input  logic [31:0]      pwdata,
  output logic [31:0]      prdata,
  output logic             pready,
  output logic             res_valid,
  output logic [ROW_W-1:0] res_row,
  output logic [COL_W-1:0] res_col,
  output logic [SUM_W-1:0] res_sum,
  input  logic             res_ready,
  output logic             frame_done
);

  logic             go;
  logic             stall;
  logic             ld_en;
  logic             sum_en;
  logic             slide_en;
  logic [ROW_W-1:0] row;
  logic [COL_W-1:0] col;

  pix_rd_if u_pix_rd_if ();
  res_if    u_res_if ();

  frame_loader u_frame_loader (
    .clk(clk), .rst_n(rst_n),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .rd(u_pix_rd_if.server), .frame_done(frame_done), .go(go)
  );

  row_controller u_row_controller (
    .clk(clk), .rst_n(rst_n), .go(go), .rd(u_pix_rd_if.client), .stall(stall),
    .ld_en(ld_en), .sum_en(sum_en), .slide_en(slide_en),
    .row(row), .col(col), .frame_done(frame_done)
  );

  window_accum u_window_accum (
    .clk(clk), .rst_n(rst_n),
    .ld_en(ld_en), .sum_en(sum_en), .slide_en(slide_en),
    .row(row), .col(col),
    .rd(u_pix_rd_if.data), .res(u_res_if.producer), .stall(stall)
  );

  result_queue u_result_queue (
    .clk(clk), .rst_n(rst_n), .res(u_res_if.consumer),
    .res_valid(res_valid), .res_row(res_row), .res_col(res_col),
    .res_sum(res_sum), .res_ready(res_ready)
  );

endmodule

// File: verilog/wsum_pkg.sv
package wsum_pkg;

  // frame geometry.
  localparam int COLS = 16;
  localparam int ROWS = 4;
  localparam int WIN  = 8;   // window length in pixels.

  // datapath widths.
  localparam int PIX_W  = 8;
  localparam int SUM_W  = PIX_W + $clog2(WIN);   // 255 * WIN still fits.
  localparam int ADDR_W = $clog2(ROWS * COLS);
  localparam int COL_W  = $clog2(COLS);
  localparam int ROW_W  = $clog2(ROWS);
  localparam int RES_W  = ROW_W + COL_W + SUM_W; // {row, col, sum}.

  localparam int Q_DEPTH = 4;

  // pixel words take every aligned address of the 8-bit map.
  // the two registers sit on unaligned byte offsets.
  localparam logic [7:0] PIX_BASE   = 8'h00;
  localparam logic [7:0] REG_CTRL   = 8'h01;  // bit 0 starts a run.
  localparam logic [7:0] REG_STATUS = 8'h02;  // bit 0 busy, bit 1 done.

  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    START     = 3'd1,
    START_ROW = 3'd2,
    FILL      = 3'd3,
    SLIDE     = 3'd4,
    FINISH    = 3'd5
  } ctrl_state_t;

endpackage
